//--- Bender.yml
package:
  name: lcd_ctrl

export_include_dirs:
  - hw

sources:
  - hw/lcd_pkg.sv
  - hw/lcd_xfer_if.sv
  - hw/lcd_cmd_decode.sv
  - hw/lcd_bus_timing.sv
  - hw/lcd_status.sv
  - hw/lcd_ctrl_top.sv
  - target: test
    files:
      - verification/lcd_ctrl_tb.sv

//--- flist.f
+incdir+hw
hw/lcd_pkg.sv
hw/lcd_xfer_if.sv
hw/lcd_cmd_decode.sv
hw/lcd_bus_timing.sv
hw/lcd_status.sv
hw/lcd_ctrl_top.sv
verification/lcd_ctrl_tb.sv

//--- hw/lcd_bus_timing.sv
`timescale 1ns/1ns
`include "lcd_params.svh"

module lcd_bus_timing (
	input  logic       clk,
	input  logic       rst_n,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data,
	lcd_xfer_if.exe    xfer
);
	import lcd_pkg::*;

	localparam logic [`LCD_CNT_W-1:0] setup_cyc =
		`LCD_CNT_W'(`LCD_SETUP_US * `LCD_CYC_PER_US);
	localparam logic [`LCD_CNT_W-1:0] pulse_end =
		`LCD_CNT_W'((`LCD_SETUP_US + `LCD_PULSE_US) * `LCD_CYC_PER_US);
	localparam logic [`LCD_CNT_W-1:0] short_cyc =
		`LCD_CNT_W'(`LCD_SHORT_US * `LCD_CYC_PER_US);
	localparam logic [`LCD_CNT_W-1:0] long_cyc =
		`LCD_CNT_W'(`LCD_LONG_US * `LCD_CYC_PER_US);

	logic [`LCD_CNT_W-1:0] cnt;    // cycles since start
	logic [`LCD_CNT_W-1:0] total;
	logic                   on_bus;

	assign total = (xfer.wait_cls == wait_long) ? long_cyc : short_cyc;

	assign xfer.done   = xfer.active && (cnt == total);
	assign xfer.e_fall = e && (cnt == pulse_end - 1'b1);

	// pins carry the transfer from start until done
	assign on_bus   = xfer.start || xfer.active;
	assign rs       = on_bus && xfer.rs;
	assign rw       = on_bus && xfer.rw;
	assign lcd_data = on_bus ? xfer.data : 8'h00;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			xfer.active <= 1'b0;
			cnt         <= '0;
			e           <= 1'b0;
		end else begin
			if (xfer.active) begin
				if (xfer.done) begin
					xfer.active <= 1'b0;
					cnt         <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end else if (xfer.start) begin
				xfer.active <= 1'b1;
				cnt         <= `LCD_CNT_W'(1);  // start cycle counts as zero
			end
			// e follows cnt+1, registered so the strobe is clean
			e <= xfer.active && !xfer.done &&
				(cnt >= setup_cyc - 1'b1) && (cnt < pulse_end - 1'b1);
		end
	end

endmodule

//--- hw/lcd_cmd_decode.sv
`timescale 1ns/1ns
`include "lcd_params.svh"

module lcd_cmd_decode (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [6:0] lcd_config,  // {lines, font, disp, cursor, blink, inc, shift}
	input  logic       lcd_enable,
	input  logic [9:0] lcd_bus,     // {rs, rw, payload}
	output logic       init_done,
	output logic       host_busy,
	lcd_xfer_if.dec    xfer
);
	import lcd_pkg::*;

	localparam logic [`LCD_CNT_W-1:0] powerup_cyc =
		`LCD_CNT_W'(`LCD_POWERUP_US * `LCD_CYC_PER_US);

	typedef enum logic [1:0] {
		st_powerup,
		st_init,
		st_ready
	} dec_state_e;

	dec_state_e             state;
	logic [`LCD_CNT_W-1:0] pwr_cnt;
	logic [1:0]             init_idx;
	logic                   issue;
	logic                   host_take;
	logic                   nxt_rs;
	logic                   nxt_rw;
	lcd_payload_u           nxt_data;

	// init command bytes, 8-bit interface always
	function automatic logic [7:0] init_cmd(input logic [1:0] idx, input logic [6:0] cfg);
		logic [7:0] cmd;
		case (idx)
			2'd0: cmd = {4'b0011, cfg[6], cfg[5], 2'b00};  // function set
			2'd1: cmd = {5'b00001, cfg[4], cfg[3], cfg[2]};  // display control
			2'd2: cmd = 8'h01;  // clear
			default: cmd = {6'b000001, cfg[1], cfg[0]};  // entry mode
		endcase
		return cmd;
	endfunction

	// only clear and return-home need the long settle
	function automatic lcd_wait_e wait_of(input logic is_char, input lcd_payload_u pl);
		lcd_instr_t ins;
		ins = pl.instr;
		if (is_char)
			return wait_short;
		if ({ins.set_ddram, ins.set_cgram, ins.func_set, ins.shift,
				ins.disp_ctrl, ins.entry_mode} != 6'b0)
			return wait_short;
		if (ins.home || ins.clear)
			return wait_long;
		return wait_short;
	endfunction

	assign host_take = (state == st_ready) && lcd_enable && !host_busy && !xfer.active;

	always_comb begin
		issue       = 1'b0;
		nxt_rs      = 1'b0;
		nxt_rw      = 1'b0;
		nxt_data.ch = init_cmd(init_idx, lcd_config);
		case (state)
			st_powerup: begin
				if (pwr_cnt == powerup_cyc - 1'b1) begin
					issue       = 1'b1;
					nxt_data.ch = init_cmd(2'd0, lcd_config);
				end
			end
			st_init: begin
				if (xfer.done && init_idx != 2'd3) begin
					issue       = 1'b1;
					nxt_data.ch = init_cmd(init_idx + 2'd1, lcd_config);
				end
			end
			default: begin
				if (host_take) begin
					issue       = 1'b1;
					nxt_rs      = lcd_bus[9];
					nxt_rw      = lcd_bus[8];
					nxt_data.ch = lcd_bus[7:0];
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= st_powerup;
			pwr_cnt    <= '0;
			init_idx   <= 2'd0;
			init_done  <= 1'b0;
			host_busy  <= 1'b0;
			xfer.start <= 1'b0;
		end else begin
			xfer.start <= issue;
			if (xfer.done)
				host_busy <= 1'b0;
			if (issue)
				host_busy <= 1'b1;  // pending until done
			case (state)
				st_powerup: begin
					pwr_cnt <= pwr_cnt + 1'b1;
					if (issue)
						state <= st_init;
				end
				st_init: begin
					if (xfer.done) begin
						if (init_idx == 2'd3) begin
							state     <= st_ready;
							init_done <= 1'b1;
						end else begin
							init_idx <= init_idx + 2'd1;
						end
					end
				end
				default: ;
			endcase
		end
	end

	// transfer contents, held while execute runs
	always_ff @(posedge clk) begin
		if (issue) begin
			xfer.rs       <= nxt_rs;
			xfer.rw       <= nxt_rw;
			xfer.data     <= nxt_data;
			xfer.wait_cls <= wait_of(nxt_rs, nxt_data);
		end
	end

endmodule

//--- hw/lcd_ctrl_top.sv
`timescale 1ns/1ns

module lcd_ctrl_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [6:0]           lcd_config,
	input  logic                 lcd_enable,
	input  logic [9:0]           lcd_bus,
	input  logic [7:0]           lcd_rd_data,
	output logic                 e,
	output logic                 rs,
	output logic                 rw,
	output lcd_pkg::lcd_payload_u lcd_data,
	output logic                 busy,
	output logic                 init_done,
	output logic [7:0]           rd_data,
	output logic                 rd_valid
);

	logic host_busy;

	lcd_xfer_if xfer_if ();

	// decode stage, init sequence and host words
	lcd_cmd_decode dec_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.lcd_config (lcd_config),
		.lcd_enable (lcd_enable),
		.lcd_bus    (lcd_bus),
		.init_done  (init_done),
		.host_busy  (host_busy),
		.xfer       (xfer_if.dec)
	);

	// execute stage, display pin timing
	lcd_bus_timing exe_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.e        (e),
		.rs       (rs),
		.rw       (rw),
		.lcd_data (lcd_data),
		.xfer     (xfer_if.exe)
	);

	lcd_status res_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.init_done   (init_done),
		.host_busy   (host_busy),
		.lcd_rd_data (lcd_rd_data),
		.busy        (busy),
		.rd_data     (rd_data),
		.rd_valid    (rd_valid),
		.xfer        (xfer_if.res)
	);

endmodule

//--- hw/lcd_params.svh
`ifndef LCD_PARAMS_SVH
`define LCD_PARAMS_SVH

// clock rate, 35 MHz system clock
`define LCD_CYC_PER_US 35

// display power-up wait before the first command
`define LCD_POWERUP_US 500

// e low before the enable pulse
`define LCD_SETUP_US 1

// e high time
`define LCD_PULSE_US 13

// whole transfer length, measured from start
`define LCD_SHORT_US 50
`define LCD_LONG_US 200

// wide enough for the power-up count (17500 cycles)
`define LCD_CNT_W 15

`endif

//--- hw/lcd_pkg.sv
package lcd_pkg;

	// one-hot style instruction view, leading one selects the command
	typedef struct packed {
		logic set_ddram;  // bit 7
		logic set_cgram;
		logic func_set;
		logic shift;
		logic disp_ctrl;
		logic entry_mode;
		logic home;
		logic clear;      // bit 0
	} lcd_instr_t;

	// same byte seen as a character (rs=1) or an instruction (rs=0)
	typedef union packed {
		logic [7:0] ch;
		lcd_instr_t instr;
	} lcd_payload_u;

	// settle class after the enable pulse
	typedef enum logic {
		wait_short = 1'b0,  // 50 us
		wait_long  = 1'b1   // 200 us, clear and home
	} lcd_wait_e;

endpackage

//--- hw/lcd_status.sv
`timescale 1ns/1ns

module lcd_status (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       init_done,
	input  logic       host_busy,
	input  logic [7:0] lcd_rd_data,
	output logic       busy,
	output logic [7:0] rd_data,
	output logic       rd_valid,
	lcd_xfer_if.res    xfer
);

	logic rd_capture;

	// sample the display while e is still high
	assign rd_capture = xfer.e_fall && xfer.rw;

	// host sees busy through init, a pending request, or a running transfer
	assign busy = !init_done || host_busy || xfer.active;

	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_capture;  // one pulse per read
	end

	always_ff @(posedge clk) begin
		if (rd_capture)
			rd_data <= lcd_rd_data;
	end

endmodule

//--- hw/lcd_xfer_if.sv
`timescale 1ns/1ns

interface lcd_xfer_if;
	import lcd_pkg::*;

	logic         start;     // one-cycle request from decode
	logic         rs;
	logic         rw;
	lcd_payload_u data;
	lcd_wait_e    wait_cls;
	logic         active;    // execute busy with a transfer
	logic         e_fall;    // last cycle of e high
	logic         done;      // settle time over

	modport dec (output start, rs, rw, data, wait_cls, input active, done);
	modport exe (input start, rs, rw, data, wait_cls, output active, e_fall, done);
	modport res (input rw, active, e_fall);

endinterface

//--- verification/lcd_ctrl_tb.sv
`timescale 1ns/1ns
`include "lcd_params.svh"

module lcd_ctrl_tb;

	localparam int pulse_cyc  = `LCD_PULSE_US * `LCD_CYC_PER_US;
	localparam int short_cyc  = `LCD_SHORT_US * `LCD_CYC_PER_US;
	localparam int long_cyc   = `LCD_LONG_US * `LCD_CYC_PER_US;
	localparam int init_limit = (`LCD_POWERUP_US + 4 * `LCD_LONG_US) * `LCD_CYC_PER_US + 1000;

	typedef struct packed {
		logic        rs;
		logic        rw;
		logic [7:0]  data;
		logic [31:0] min_busy;  // cycles busy must stay high
	} xfer_exp_t;

	logic       clk;
	logic       rst_n;
	logic [6:0] lcd_config;
	logic       lcd_enable;
	logic [9:0] lcd_bus;
	logic [7:0] lcd_rd_data;
	logic       e;
	logic       rs;
	logic       rw;
	logic [7:0] lcd_data;
	logic       busy;
	logic       init_done;
	logic [7:0] rd_data;
	logic       rd_valid;

	xfer_exp_t exp_q[$];
	int        err_cnt = 0;
	int        pass_cnt = 0;
	int        fail_cnt = 0;
	int        rd_cnt = 0;
	int        hi_cnt = 0;
	logic      e_prev = 1'b0;

	lcd_ctrl_top dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.lcd_config  (lcd_config),
		.lcd_enable  (lcd_enable),
		.lcd_bus     (lcd_bus),
		.lcd_rd_data (lcd_rd_data),
		.e           (e),
		.rs          (rs),
		.rw          (rw),
		.lcd_data    (lcd_data),
		.busy        (busy),
		.init_done   (init_done),
		.rd_data     (rd_data),
		.rd_valid    (rd_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// HD44780 command encoding and settle class per instruction
	function automatic xfer_exp_t expected_xfer(input logic is_init, input logic [1:0] idx,
			input logic [6:0] cfg, input logic [9:0] word);
		xfer_exp_t x;
		logic      long_cls;
		if (is_init) begin
			x.rs = 1'b0;
			x.rw = 1'b0;
			case (idx)
				2'd0: x.data = {4'b0011, cfg[6:5], 2'b00};  // 8-bit bus, lines, font
				2'd1: x.data = {5'b00001, cfg[4:2]};
				2'd2: x.data = 8'h01;
				default: x.data = {6'b000001, cfg[1:0]};
			endcase
		end else begin
			x.rs   = word[9];
			x.rw   = word[8];
			x.data = word[7:0];
		end
		long_cls   = !x.rs && (x.data == 8'h01 || x.data[7:1] == 7'h01);  // clear or home
		x.min_busy = long_cls ? long_cyc : short_cyc;
		return x;
	endfunction

	function automatic logic [7:0] random_short_instr();
		logic [31:0] r;
		r = $urandom;
		case (r[31:29] % 5)
			0: return 8'h80 | r[6:0];
			1: return 8'h20 | r[4:0];
			2: return 8'h10 | r[3:0];
			3: return 8'h08 | r[2:0];
			default: return 8'h04 | r[1:0];
		endcase
	endfunction

	task automatic report_mismatch(input string sig, input logic [31:0] exp,
			input logic [31:0] got);
		err_cnt++;
		$display("ERROR %s expected %h got %h", sig, exp, got);
	endtask

	task automatic note_failure(input string msg);
		err_cnt++;
		$display("%s", msg);
	endtask

	task automatic abort_run(input string what);
		$display("timeout while waiting for %s", what);
		$display(">>> FAIL");
		$finish;
	endtask

	task automatic end_test(input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			pass_cnt++;
			$display("test %s: passed", name);
		end else begin
			fail_cnt++;
			$display("test %s: failed with %0d errors", name, err_cnt - errs_before);
		end
	endtask

	task automatic check_rise();
		xfer_exp_t x;
		assert (exp_q.size() > 0)
		else note_failure($sformatf("e pulse seen with no transfer expected, data %h", lcd_data));
		if (exp_q.size() > 0) begin
			x = exp_q.pop_front();
			assert (rs === x.rs) else report_mismatch("rs", x.rs, rs);
			assert (rw === x.rw) else report_mismatch("rw", x.rw, rw);
			assert (lcd_data === x.data) else report_mismatch("lcd_data", x.data, lcd_data);
		end
	endtask

	// display bus monitor sampling the pins at every rising edge
	always @(posedge clk) begin
		if (e === 1'b1)
			hi_cnt = hi_cnt + 1;
		if (e === 1'b1 && !e_prev)
			check_rise();
		if (e !== 1'b1 && e_prev) begin
			assert (hi_cnt == pulse_cyc) else report_mismatch("e_high_cycles", pulse_cyc, hi_cnt);
			hi_cnt = 0;
		end
		if (rd_valid === 1'b1)
			rd_cnt++;
		e_prev = (e === 1'b1);
	end

	task automatic issue_word(input logic [9:0] word, input logic [7:0] rd_byte);
		int n;
		n = 0;
		@(posedge clk);
		while (busy !== 1'b0) begin
			@(posedge clk);
			n++;
			if (n > long_cyc + 200)
				abort_run("busy to drop before a host word");
		end
		exp_q.push_back(expected_xfer(1'b0, 2'd0, 7'd0, word));
		lcd_bus     <= word;
		lcd_rd_data <= rd_byte;
		lcd_enable  <= 1'b1;
		@(posedge clk);  // taken at this edge
		lcd_enable  <= 1'b0;
	endtask

	task automatic measure_busy(output int cyc);
		cyc = 0;
		@(posedge clk);
		while (busy === 1'b1) begin
			cyc++;
			if (cyc > long_cyc + 200)
				abort_run("busy to drop after a transfer");
			@(posedge clk);
		end
	endtask

	task automatic send_word(input logic [9:0] word, input logic [7:0] rd_byte);
		xfer_exp_t x;
		int        cyc;
		x = expected_xfer(1'b0, 2'd0, 7'd0, word);
		issue_word(word, rd_byte);
		measure_busy(cyc);
		assert (cyc >= x.min_busy) else report_mismatch("busy_cycles", x.min_busy, cyc);
		assert (cyc <= x.min_busy + 4) else report_mismatch("busy_cycles", x.min_busy, cyc);
	endtask

	initial begin
		int          errs;
		int          n;
		int          cyc;
		int          rd_before;
		logic [6:0]  cfg;
		logic [9:0]  word;
		logic [7:0]  rbyte;
		cfg         = $urandom(32'hb419_d3f7);  // first draw also seeds the generator
		rst_n       = 1'b0;
		lcd_config  = cfg;
		lcd_enable  = 1'b0;
		lcd_bus     = '0;
		lcd_rd_data = '0;

		errs = err_cnt;
		for (int i = 0; i < 4; i++)
			exp_q.push_back(expected_xfer(1'b1, i[1:0], cfg, 10'd0));
		repeat (16) @(posedge clk);
		assert ({e, rs, rw, lcd_data, rd_valid, init_done} === 13'd0)
		else report_mismatch("reset_outputs", 0, {e, rs, rw, lcd_data, rd_valid, init_done});
		assert (busy === 1'b1) else report_mismatch("busy", 1, busy);
		rst_n <= 1'b1;
		n = 0;
		while (init_done !== 1'b1) begin
			assert (busy === 1'b1) else report_mismatch("busy", 1, busy);
			@(posedge clk);
			n++;
			if (n > init_limit)
				abort_run("init_done");
		end
		assert (busy === 1'b0) else report_mismatch("busy", 0, busy);
		assert (exp_q.size() == 0) else note_failure("init commands missing from the display bus");
		end_test("init", errs);

		errs = err_cnt;
		rd_before = rd_cnt;
		for (int i = 0; i < 8; i++) begin
			if (i % 2)
				word = {2'b10, 8'($urandom)};  // character write
			else
				word = {2'b00, random_short_instr()};
			send_word(word, 8'h00);
		end
		assert (rd_cnt == rd_before) else report_mismatch("rd_valid_count", rd_before, rd_cnt);
		end_test("host_writes", errs);

		errs = err_cnt;
		send_word(10'h001, 8'h00);  // clear
		send_word(10'h002, 8'h00);  // home
		send_word(10'h003, 8'h00);  // home with the low bit set
		send_word({2'b00, random_short_instr()}, 8'h00);
		send_word({2'b00, random_short_instr()}, 8'h00);
		end_test("wait_classes", errs);

		errs = err_cnt;
		for (int i = 0; i < 4; i++) begin
			word      = {1'($urandom), 1'b1, 8'($urandom)};
			rbyte     = $urandom;
			rd_before = rd_cnt;
			send_word(word, rbyte);
			assert (rd_cnt == rd_before + 1)
			else report_mismatch("rd_valid_count", rd_before + 1, rd_cnt);
			assert (rd_data === rbyte) else report_mismatch("rd_data", rbyte, rd_data);
		end
		end_test("reads", errs);

		errs = err_cnt;
		issue_word(10'h001, 8'h00);  // long clear keeps busy up
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			lcd_bus    <= {2'b10, 8'($urandom)};
			lcd_enable <= i[0];  // ignored while busy
		end
		word = {2'b10, 8'($urandom)};
		exp_q.push_back(expected_xfer(1'b0, 2'd0, 7'd0, word));
		@(posedge clk);
		lcd_bus    <= word;
		lcd_enable <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
			if (n > long_cyc + 200)
				abort_run("the held host word to be taken");
		end while (busy !== 1'b0);
		lcd_enable <= 1'b0;
		measure_busy(cyc);
		assert (cyc >= short_cyc) else report_mismatch("busy_cycles", short_cyc, cyc);
		assert (exp_q.size() == 0) else note_failure("held host word never reached the display bus");
		end_test("backpressure", errs);

		$display("tests passed %0d, failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
